// ==== logic/dma_pkg.sv ====
`default_nettype none

package dma_pkg;

  //////////////////////////////////////////////////////////////////////
  // Bus and flit widths
  //////////////////////////////////////////////////////////////////////

  localparam int ADDR_WIDTH      = 32;
  localparam int DATA_WIDTH      = 32;
  localparam int WORD_BYTES      = 4;    // Full words only
  localparam int FLIT_KIND_WIDTH = 2;
  localparam int FLIT_WIDTH      = FLIT_KIND_WIDTH + DATA_WIDTH;  // 34

  // NoC flit, kind on top of content
  typedef struct packed {
    logic [FLIT_KIND_WIDTH-1:0] kind;
    logic [DATA_WIDTH-1:0]      content;
  } flit_t;

  // Flit kind codes
  localparam logic [FLIT_KIND_WIDTH-1:0] FLIT_KIND_MIDDLE = 2'b00;
  localparam logic [FLIT_KIND_WIDTH-1:0] FLIT_KIND_FIRST  = 2'b01;
  localparam logic [FLIT_KIND_WIDTH-1:0] FLIT_KIND_LAST   = 2'b10;
  localparam logic [FLIT_KIND_WIDTH-1:0] FLIT_KIND_SINGLE = 2'b11;

  //////////////////////////////////////////////////////////////////////
  // Header layout, bit positions inside the flit content
  //////////////////////////////////////////////////////////////////////

  localparam int TABLE_ENTRIES   = 4;
  localparam int TABLE_PTR_WIDTH = $clog2(TABLE_ENTRIES);  // 2

  localparam int PKT_TYPE_WIDTH  = 2;
  localparam int PKT_TYPE_MSB    = 31;
  localparam int PKT_TYPE_LSB    = 30;
  localparam int PKT_RESP_LAST   = 29;   // Last packet of a response
  localparam int PKT_ID_MSB      = TABLE_PTR_WIDTH - 1;
  localparam int PKT_ID_LSB      = 0;

  // Packet types, anything else is dropped
  localparam logic [PKT_TYPE_WIDTH-1:0] PKT_L2R_RESP = 2'd1;
  localparam logic [PKT_TYPE_WIDTH-1:0] PKT_R2L_RESP = 2'd2;

  localparam int PACKET_DEPTH = 16;      // Flit buffer per channel

  // Wishbone cycle type identifiers
  localparam int                    CTI_WIDTH = 3;
  localparam logic [CTI_WIDTH-1:0] CTI_INCR  = 3'b010;
  localparam logic [CTI_WIDTH-1:0] CTI_END   = 3'b111;

endpackage

`default_nettype wire

// ==== logic/dma_flit_fifo.sv ====
`default_nettype none

module dma_flit_fifo #(
  parameter int DEPTH = 16
) (
  input  logic           clk,
  input  logic           rst,
  input  dma_pkg::flit_t in_flit_i,
  input  logic           in_valid_i,
  output logic           in_ready_o,
  output dma_pkg::flit_t out_flit_o,
  output logic           out_valid_o,
  input  logic           out_ready_i
);

  localparam int PTR_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_WIDTH = $clog2(DEPTH + 1);

  dma_pkg::flit_t       mem [DEPTH];   // Flit storage
  logic [PTR_WIDTH-1:0] wr_ptr_q;
  logic [PTR_WIDTH-1:0] rd_ptr_q;
  logic [CNT_WIDTH-1:0] count_q;       // Occupancy
  logic [CNT_WIDTH-1:0] count_d;
  logic                 ready_q;       // Registered not-full
  logic                 push;
  logic                 pop;

  assign push        = in_valid_i & ready_q;
  assign pop         = out_valid_o & out_ready_i;
  assign in_ready_o  = ready_q;
  assign out_valid_o = (count_q != '0);
  assign out_flit_o  = mem[rd_ptr_q];  // Head always visible

  assign count_d = count_q + CNT_WIDTH'(push) - CNT_WIDTH'(pop);

  //////////////////////////////////////////////////////////////////////
  // Pointers and count
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      ready_q  <= 1'b0;                // Low in reset, up one cycle later
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_WIDTH'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_WIDTH'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q <= count_d;
      ready_q <= (count_d != CNT_WIDTH'(DEPTH));  // Drop when full
    end
  end

  // Storage write
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr_q] <= in_flit_i;
    end
  end

endmodule

`default_nettype wire

// ==== logic/dma_resp_writer.sv ====
`default_nettype none

module dma_resp_writer (
  input  logic                                clk,
  input  logic                                rst,
  input  dma_pkg::flit_t                      flit_i,
  input  logic                                flit_valid_i,
  output logic                                flit_ready_o,
  output logic                                wb_cyc_o,
  output logic                                wb_stb_o,
  output logic                                wb_we_o,
  output logic [dma_pkg::ADDR_WIDTH-1:0]      wb_adr_o,
  output logic [dma_pkg::DATA_WIDTH-1:0]      wb_dat_o,
  output logic [dma_pkg::CTI_WIDTH-1:0]       wb_cti_o,
  input  logic                                wb_ack_i,
  output logic                                done_en_o,
  output logic [dma_pkg::TABLE_PTR_WIDTH-1:0] done_pos_o
);

  typedef enum logic [1:0] {
    ST_IDLE,      // Waiting for a header
    ST_GET_SIZE,  // Size flit, not needed here
    ST_GET_ADDR,  // Start address
    ST_DATA       // Burst of data flits
  } state_t;

  state_t                              state_q;
  state_t                              state_d;
  logic [dma_pkg::TABLE_PTR_WIDTH-1:0] resp_id_q;
  logic [dma_pkg::TABLE_PTR_WIDTH-1:0] resp_id_d;
  logic                                resp_last_q;  // Completes the entry
  logic                                resp_last_d;
  logic [dma_pkg::ADDR_WIDTH-1:0]      addr_q;       // Running address
  logic [dma_pkg::ADDR_WIDTH-1:0]      addr_d;

  logic                                is_head;
  logic                                last_flit;
  logic [dma_pkg::PKT_TYPE_WIDTH-1:0]  pkt_type;
  logic [dma_pkg::TABLE_PTR_WIDTH-1:0] hdr_id;
  logic                                beat_done;

  //////////////////////////////////////////////////////////////////////
  // Flit decode
  //////////////////////////////////////////////////////////////////////

  assign is_head   = (flit_i.kind == dma_pkg::FLIT_KIND_FIRST) |
                     (flit_i.kind == dma_pkg::FLIT_KIND_SINGLE);
  assign last_flit = (flit_i.kind == dma_pkg::FLIT_KIND_LAST) |
                     (flit_i.kind == dma_pkg::FLIT_KIND_SINGLE);
  assign pkt_type  = flit_i.content[dma_pkg::PKT_TYPE_MSB:dma_pkg::PKT_TYPE_LSB];
  assign hdr_id    = flit_i.content[dma_pkg::PKT_ID_MSB:dma_pkg::PKT_ID_LSB];
  assign beat_done = flit_valid_i & wb_ack_i;  // Only meaningful in ST_DATA

  // Bus payload straight from the buffered flit
  assign wb_adr_o = addr_q;
  assign wb_dat_o = flit_i.content;
  assign wb_cti_o = last_flit ? dma_pkg::CTI_END : dma_pkg::CTI_INCR;

  //////////////////////////////////////////////////////////////////////
  // Next state and outputs
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d      = state_q;
    resp_id_d    = resp_id_q;
    resp_last_d  = resp_last_q;
    addr_d       = addr_q;
    flit_ready_o = 1'b0;
    wb_cyc_o     = 1'b0;
    wb_stb_o     = 1'b0;
    wb_we_o      = 1'b0;
    done_en_o    = 1'b0;
    done_pos_o   = resp_id_q;

    case (state_q)
      ST_IDLE: begin
        flit_ready_o = 1'b1;           // Stray and unknown flits drain here
        if (flit_valid_i && is_head) begin
          if (pkt_type == dma_pkg::PKT_L2R_RESP) begin
            done_en_o  = 1'b1;         // Header only, complete now
            done_pos_o = hdr_id;
          end else if (pkt_type == dma_pkg::PKT_R2L_RESP) begin
            resp_id_d   = hdr_id;
            resp_last_d = flit_i.content[dma_pkg::PKT_RESP_LAST];
            state_d     = ST_GET_SIZE;
          end
        end
      end

      ST_GET_SIZE: begin
        flit_ready_o = 1'b1;
        if (flit_valid_i) begin
          state_d = ST_GET_ADDR;
        end
      end

      ST_GET_ADDR: begin
        flit_ready_o = 1'b1;
        if (flit_valid_i) begin
          addr_d  = flit_i.content;
          state_d = ST_DATA;
        end
      end

      ST_DATA: begin
        wb_cyc_o     = 1'b1;           // Hold the bus for the whole burst
        wb_stb_o     = flit_valid_i;   // Beat only with a flit in hand
        wb_we_o      = 1'b1;
        flit_ready_o = wb_ack_i;       // Pop on ack
        if (beat_done) begin
          addr_d = addr_q + dma_pkg::ADDR_WIDTH'(dma_pkg::WORD_BYTES);
          if (last_flit) begin
            state_d    = ST_IDLE;
            done_en_o  = resp_last_q;
            done_pos_o = resp_id_q;
          end
        end
      end

      default: begin
        state_d = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Header and address payload
  always_ff @(posedge clk) begin
    resp_id_q   <= resp_id_d;
    resp_last_q <= resp_last_d;
    addr_q      <= addr_d;
  end

endmodule

`default_nettype wire

// ==== logic/dma_wb_arbiter.sv ====
`default_nettype none

module dma_wb_arbiter (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           req0_cyc_i,
  input  logic                           req0_stb_i,
  input  logic                           req0_we_i,
  input  logic [dma_pkg::ADDR_WIDTH-1:0] req0_adr_i,
  input  logic [dma_pkg::DATA_WIDTH-1:0] req0_dat_i,
  input  logic [dma_pkg::CTI_WIDTH-1:0]  req0_cti_i,
  output logic                           req0_ack_o,
  input  logic                           req1_cyc_i,
  input  logic                           req1_stb_i,
  input  logic                           req1_we_i,
  input  logic [dma_pkg::ADDR_WIDTH-1:0] req1_adr_i,
  input  logic [dma_pkg::DATA_WIDTH-1:0] req1_dat_i,
  input  logic [dma_pkg::CTI_WIDTH-1:0]  req1_cti_i,
  output logic                           req1_ack_o,
  output logic                           wb_cyc_o,
  output logic                           wb_stb_o,
  output logic                           wb_we_o,
  output logic [dma_pkg::ADDR_WIDTH-1:0] wb_adr_o,
  output logic [dma_pkg::DATA_WIDTH-1:0] wb_dat_o,
  output logic [dma_pkg::CTI_WIDTH-1:0]  wb_cti_o,
  output logic [dma_pkg::WORD_BYTES-1:0] wb_sel_o,
  input  logic                           wb_ack_i
);

  logic [1:0] grant_q;    // One-hot, zero while the bus is free
  logic       last_q;     // Writer served last
  logic       pick1;      // Round-robin choice
  logic       burst_end;

  // Writer 1 wins alone, or on a tie when writer 0 went last
  assign pick1 = req1_cyc_i & (~req0_cyc_i | ~last_q);

  //////////////////////////////////////////////////////////////////////
  // Bus mux
  //////////////////////////////////////////////////////////////////////

  assign wb_cyc_o = (grant_q[0] & req0_cyc_i) | (grant_q[1] & req1_cyc_i);
  assign wb_stb_o = (grant_q[0] & req0_stb_i) | (grant_q[1] & req1_stb_i);
  assign wb_we_o  = grant_q[1] ? req1_we_i  : req0_we_i;
  assign wb_adr_o = grant_q[1] ? req1_adr_i : req0_adr_i;
  assign wb_dat_o = grant_q[1] ? req1_dat_i : req0_dat_i;
  assign wb_cti_o = grant_q[1] ? req1_cti_i : req0_cti_i;
  assign wb_sel_o = '1;                  // Word writes only

  // Ack back to the owner only
  assign req0_ack_o = wb_ack_i & grant_q[0];
  assign req1_ack_o = wb_ack_i & grant_q[1];

  assign burst_end = wb_cyc_o & wb_stb_o & wb_ack_i &
                     (wb_cti_o == dma_pkg::CTI_END);

  //////////////////////////////////////////////////////////////////////
  // Grant, held for a whole burst
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      grant_q <= 2'b00;
      last_q  <= 1'b1;                   // First tie goes to writer 0
    end else if (grant_q == 2'b00) begin
      if (req0_cyc_i | req1_cyc_i) begin
        grant_q <= pick1 ? 2'b10 : 2'b01;
        last_q  <= pick1;
      end
    end else if (burst_end | ~wb_cyc_o) begin
      grant_q <= 2'b00;                  // Free after the END beat
    end
  end

endmodule

`default_nettype wire

// ==== logic/dma_resp_top.sv ====
`default_nettype none

module dma_resp_top (
  input  logic                                clk,
  input  logic                                rst,
  input  dma_pkg::flit_t                      noc0_flit_i,
  input  logic                                noc0_valid_i,
  output logic                                noc0_ready_o,
  input  dma_pkg::flit_t                      noc1_flit_i,
  input  logic                                noc1_valid_i,
  output logic                                noc1_ready_o,
  output logic                                wb_cyc_o,
  output logic                                wb_stb_o,
  output logic                                wb_we_o,
  output logic [dma_pkg::ADDR_WIDTH-1:0]      wb_adr_o,
  output logic [dma_pkg::DATA_WIDTH-1:0]      wb_dat_o,
  output logic [dma_pkg::CTI_WIDTH-1:0]       wb_cti_o,
  output logic [dma_pkg::WORD_BYTES-1:0]      wb_sel_o,
  input  logic                                wb_ack_i,
  output logic                                done0_en_o,
  output logic [dma_pkg::TABLE_PTR_WIDTH-1:0] done0_pos_o,
  output logic                                done1_en_o,
  output logic [dma_pkg::TABLE_PTR_WIDTH-1:0] done1_pos_o
);

  // FIFO to writer
  dma_pkg::flit_t buf0_flit, buf1_flit;
  logic           buf0_valid, buf1_valid;
  logic           buf0_ready, buf1_ready;

  // Writer to arbiter
  logic                           w0_cyc, w0_stb, w0_we, w0_ack;
  logic                           w1_cyc, w1_stb, w1_we, w1_ack;
  logic [dma_pkg::ADDR_WIDTH-1:0] w0_adr, w1_adr;
  logic [dma_pkg::DATA_WIDTH-1:0] w0_dat, w1_dat;
  logic [dma_pkg::CTI_WIDTH-1:0]  w0_cti, w1_cti;

  //////////////////////////////////////////////////////////////////////
  // Channel 0
  //////////////////////////////////////////////////////////////////////

  dma_flit_fifo #(.DEPTH(dma_pkg::PACKET_DEPTH)) i_fifo0 (
    .clk(clk), .rst(rst),
    .in_flit_i(noc0_flit_i), .in_valid_i(noc0_valid_i), .in_ready_o(noc0_ready_o),
    .out_flit_o(buf0_flit), .out_valid_o(buf0_valid), .out_ready_i(buf0_ready)
  );

  dma_resp_writer i_writer0 (
    .clk(clk), .rst(rst),
    .flit_i(buf0_flit), .flit_valid_i(buf0_valid), .flit_ready_o(buf0_ready),
    .wb_cyc_o(w0_cyc), .wb_stb_o(w0_stb), .wb_we_o(w0_we),
    .wb_adr_o(w0_adr), .wb_dat_o(w0_dat), .wb_cti_o(w0_cti), .wb_ack_i(w0_ack),
    .done_en_o(done0_en_o), .done_pos_o(done0_pos_o)
  );

  //////////////////////////////////////////////////////////////////////
  // Channel 1
  //////////////////////////////////////////////////////////////////////

  dma_flit_fifo #(.DEPTH(dma_pkg::PACKET_DEPTH)) i_fifo1 (
    .clk(clk), .rst(rst),
    .in_flit_i(noc1_flit_i), .in_valid_i(noc1_valid_i), .in_ready_o(noc1_ready_o),
    .out_flit_o(buf1_flit), .out_valid_o(buf1_valid), .out_ready_i(buf1_ready)
  );

  dma_resp_writer i_writer1 (
    .clk(clk), .rst(rst),
    .flit_i(buf1_flit), .flit_valid_i(buf1_valid), .flit_ready_o(buf1_ready),
    .wb_cyc_o(w1_cyc), .wb_stb_o(w1_stb), .wb_we_o(w1_we),
    .wb_adr_o(w1_adr), .wb_dat_o(w1_dat), .wb_cti_o(w1_cti), .wb_ack_i(w1_ack),
    .done_en_o(done1_en_o), .done_pos_o(done1_pos_o)
  );

  // Shared master port
  dma_wb_arbiter i_arbiter (
    .clk(clk), .rst(rst),
    .req0_cyc_i(w0_cyc), .req0_stb_i(w0_stb), .req0_we_i(w0_we),
    .req0_adr_i(w0_adr), .req0_dat_i(w0_dat), .req0_cti_i(w0_cti), .req0_ack_o(w0_ack),
    .req1_cyc_i(w1_cyc), .req1_stb_i(w1_stb), .req1_we_i(w1_we),
    .req1_adr_i(w1_adr), .req1_dat_i(w1_dat), .req1_cti_i(w1_cti), .req1_ack_o(w1_ack),
    .wb_cyc_o(wb_cyc_o), .wb_stb_o(wb_stb_o), .wb_we_o(wb_we_o),
    .wb_adr_o(wb_adr_o), .wb_dat_o(wb_dat_o), .wb_cti_o(wb_cti_o),
    .wb_sel_o(wb_sel_o), .wb_ack_i(wb_ack_i)
  );

endmodule

`default_nettype wire

// ==== verification/dma_resp_asserts.sv ====
`default_nettype none

module dma_resp_asserts (
  input logic                           clk,
  input logic                           rst,
  input logic                           cyc_i,
  input logic                           stb_i,
  input logic                           ack_i,
  input logic [dma_pkg::ADDR_WIDTH-1:0] adr_i,
  input logic [dma_pkg::DATA_WIDTH-1:0] dat_i,
  input logic [dma_pkg::CTI_WIDTH-1:0]  cti_i,
  input logic [1:0]                     grant_i   // Arbiter one-hot grant
);

  int unsigned fail_count = 0;

  // Strobe only inside a cycle
  stb_in_cyc: assert property (@(posedge clk) disable iff (rst) stb_i |-> cyc_i)
    else begin
      fail_count++;
      $error("stb high without cyc");
    end

  // Waiting beat keeps its payload
  beat_stable: assert property (@(posedge clk) disable iff (rst)
    (stb_i && !ack_i) |=> (stb_i && $stable(adr_i) && $stable(dat_i) && $stable(cti_i)))
    else begin
      fail_count++;
      $error("address, data or cti changed while a beat waited for ack");
    end

  // INCR beat is followed by more of the same writer's burst
  incr_in_burst: assert property (@(posedge clk) disable iff (rst)
    (cyc_i && stb_i && ack_i && cti_i == dma_pkg::CTI_INCR) |=> (cyc_i && $stable(grant_i)))
    else begin
      fail_count++;
      $error("burst left or changed writer after an INCR beat");
    end

endmodule

bind dma_resp_top dma_resp_asserts i_asserts (
  .clk(clk), .rst(rst), .cyc_i(wb_cyc_o), .stb_i(wb_stb_o), .ack_i(wb_ack_i),
  .adr_i(wb_adr_o), .dat_i(wb_dat_o), .cti_i(wb_cti_o), .grant_i(i_arbiter.grant_q)
);

`default_nettype wire

// ==== verification/dma_resp_tb.sv ====
`default_nettype none

module dma_resp_tb;

  localparam int NUM_PKTS  = 10;
  localparam int MAX_WORDS = 32;
  localparam int MAX_FLITS = 256;
  localparam int MEM_WORDS = 256;      // 1 KiB window from address 0

  typedef struct packed {
    logic                                ch;
    logic [dma_pkg::PKT_TYPE_WIDTH-1:0]  ptype;
    logic [dma_pkg::TABLE_PTR_WIDTH-1:0] id;
    logic                                last;   // Response-last flag
    logic [dma_pkg::ADDR_WIDTH-1:0]      addr;
    logic [7:0]                          words;
  } pkt_t;

  logic                                clk = 1'b0;
  logic                                rst;
  dma_pkg::flit_t                      noc0_flit, noc1_flit;
  logic                                noc0_valid, noc1_valid, noc0_ready, noc1_ready;
  logic                                wb_cyc, wb_stb, wb_we;
  logic                                wb_ack = 1'b0;
  logic [dma_pkg::ADDR_WIDTH-1:0]      wb_adr;
  logic [dma_pkg::DATA_WIDTH-1:0]      wb_dat;
  logic [dma_pkg::CTI_WIDTH-1:0]       wb_cti;
  logic [dma_pkg::WORD_BYTES-1:0]      wb_sel;
  logic                                done0_en, done1_en;
  logic [dma_pkg::TABLE_PTR_WIDTH-1:0] done0_pos, done1_pos;

  pkt_t                                pkt_tab [NUM_PKTS];
  logic [dma_pkg::DATA_WIDTH-1:0]      data_tab [NUM_PKTS][MAX_WORDS];
  dma_pkg::flit_t                      stream [2][MAX_FLITS];  // Flits per channel
  int                                  stream_len [2];
  logic [dma_pkg::TABLE_PTR_WIDTH-1:0] exp_done0 [$];
  logic [dma_pkg::TABLE_PTR_WIDTH-1:0] exp_done1 [$];

  // Wishbone memory model
  logic [dma_pkg::ADDR_WIDTH-1:0]      log_adr [$];            // Accepted beats in bus order
  logic [dma_pkg::DATA_WIDTH-1:0]      log_dat [$];
  logic [dma_pkg::CTI_WIDTH-1:0]       log_cti [$];
  int                                  mem_pos [MEM_WORDS];    // Log position of each word
  int                                  mem_burst [MEM_WORDS];  // Burst number of each beat
  int                                  mem_hits [MEM_WORDS];
  bit                                  mem_expected [MEM_WORDS];
  int                                  burst_no, writes_seen, total_words, ack_wait;
  int                                  cycle_count, timeout_limit;
  integer                              seed = 32'hf0cb82b5;

  dma_resp_top i_dut (
    .clk(clk), .rst(rst),
    .noc0_flit_i(noc0_flit), .noc0_valid_i(noc0_valid), .noc0_ready_o(noc0_ready),
    .noc1_flit_i(noc1_flit), .noc1_valid_i(noc1_valid), .noc1_ready_o(noc1_ready),
    .wb_cyc_o(wb_cyc), .wb_stb_o(wb_stb), .wb_we_o(wb_we), .wb_adr_o(wb_adr),
    .wb_dat_o(wb_dat), .wb_cti_o(wb_cti), .wb_sel_o(wb_sel), .wb_ack_i(wb_ack),
    .done0_en_o(done0_en), .done0_pos_o(done0_pos),
    .done1_en_o(done1_en), .done1_pos_o(done1_pos)
  );

  initial begin
    forever #20 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // Reporting and compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Test failed");
    $fatal(1, "Simulation stopped on the first error");
  endtask

  task automatic report_mismatch(input string msg);
    abort_run($sformatf("FAILED at time %0t: %s", $time, msg));
  endtask

  task automatic check_word(input logic [dma_pkg::ADDR_WIDTH-1:0] exp_adr, got_adr,
                            input logic [dma_pkg::DATA_WIDTH-1:0] exp_dat, got_dat);
    if (got_adr !== exp_adr || got_dat !== exp_dat) begin
      report_mismatch($sformatf("write %h data %h, expected %h data %h",
                                got_adr, got_dat, exp_adr, exp_dat));
    end
  endtask

  task automatic check_cti(input logic [dma_pkg::ADDR_WIDTH-1:0] adr,
                           input logic [dma_pkg::CTI_WIDTH-1:0] exp_cti, got_cti);
    if (got_cti !== exp_cti) begin
      report_mismatch($sformatf("cti %b at %h, expected %b", got_cti, adr, exp_cti));
    end
  endtask

  task automatic check_done(input int ch,
                            input logic [dma_pkg::TABLE_PTR_WIDTH-1:0] exp_id, got_id);
    if (got_id !== exp_id) begin
      report_mismatch($sformatf("done on channel %0d id %0d, expected %0d", ch, got_id, exp_id));
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Packet table to flit streams
  //////////////////////////////////////////////////////////////////////

  task automatic add_flit(input logic ch, input logic [1:0] kind,
                          input logic [dma_pkg::DATA_WIDTH-1:0] content);
    stream[ch][stream_len[ch]] = {kind, content};
    stream_len[ch]++;
  endtask

  task automatic build_packet(input int p);
    pkt_t                           pk;
    logic [dma_pkg::DATA_WIDTH-1:0] head;
    pk   = pkt_tab[p];
    head = '0;
    head[dma_pkg::PKT_TYPE_MSB:dma_pkg::PKT_TYPE_LSB] = pk.ptype;
    head[dma_pkg::PKT_RESP_LAST]                      = pk.last;
    head[dma_pkg::PKT_ID_MSB:dma_pkg::PKT_ID_LSB]     = pk.id;
    if (pk.ptype == dma_pkg::PKT_L2R_RESP) begin
      add_flit(pk.ch, dma_pkg::FLIT_KIND_SINGLE, head);   // Header only
    end else begin
      add_flit(pk.ch, dma_pkg::FLIT_KIND_FIRST, head);
      add_flit(pk.ch, dma_pkg::FLIT_KIND_MIDDLE, 32'(pk.words));  // Size
      add_flit(pk.ch, dma_pkg::FLIT_KIND_MIDDLE, pk.addr);
      for (int w = 0; w < pk.words; w++) begin
        data_tab[p][w] = $random(seed);
        add_flit(pk.ch, (w == pk.words - 1) ? dma_pkg::FLIT_KIND_LAST : dma_pkg::FLIT_KIND_MIDDLE,
                 data_tab[p][w]);
        if (pk.ptype == dma_pkg::PKT_R2L_RESP) begin
          mem_expected[int'(pk.addr >> 2) + w] = 1'b1;
          total_words++;
        end
      end
    end
    // Completions expected in table order
    if (pk.ptype == dma_pkg::PKT_L2R_RESP ||
        (pk.ptype == dma_pkg::PKT_R2L_RESP && pk.last)) begin
      if (pk.ch) begin
        exp_done1.push_back(pk.id);
      end else begin
        exp_done0.push_back(pk.id);
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Monitors
  //////////////////////////////////////////////////////////////////////

  // Slave acks after 0 to 3 extra cycles
  always @(posedge clk) begin : wb_memory
    int idx;
    idx = int'(wb_adr[9:2]);
    if (rst) begin
      wb_ack   <= 1'b0;
      ack_wait = 0;
    end else if (wb_ack) begin
      wb_ack <= 1'b0;
      if (wb_stb) begin                   // Beat accepted on this edge
        if (wb_adr >= MEM_WORDS * 4 || wb_adr[1:0] != 2'b00 || !wb_we || wb_sel != '1) begin
          abort_run($sformatf("Write to %h is not a full word inside the memory", wb_adr));
        end else if (!mem_expected[idx]) begin
          abort_run($sformatf("Write to %h that no packet asked for", wb_adr));
        end else if (mem_hits[idx] != 0) begin
          abort_run($sformatf("Word at %h written twice", wb_adr));
        end
        mem_pos[idx]   = log_adr.size();
        mem_burst[idx] = burst_no;
        mem_hits[idx]++;
        log_adr.push_back(wb_adr);
        log_dat.push_back(wb_dat);
        log_cti.push_back(wb_cti);
        writes_seen++;
        if (wb_cti == dma_pkg::CTI_END) begin
          burst_no++;
        end
      end
    end else if (wb_cyc && wb_stb) begin
      if (ack_wait == 0) begin
        wb_ack   <= 1'b1;
        ack_wait = $random(seed) & 3;
      end else begin
        ack_wait--;
      end
    end
  end

  always @(posedge clk) begin
    if (!rst && done0_en) begin
      if (exp_done0.size() == 0) begin
        abort_run("Done pulse on channel 0 with no completion pending");
      end
      check_done(0, exp_done0.pop_front(), done0_pos);
    end
    if (!rst && done1_en) begin
      if (exp_done1.size() == 0) begin
        abort_run("Done pulse on channel 1 with no completion pending");
      end
      check_done(1, exp_done1.pop_front(), done1_pos);
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > timeout_limit) begin
      abort_run($sformatf("Timeout after %0d cycles with the DUT still busy", cycle_count));
    end
    if (i_dut.i_asserts.fail_count != 0) begin
      abort_run("A Wishbone protocol assertion fired");
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    int idx;
    int first;
    int pos;
    rst        = 1'b1;
    noc0_flit  = '0;
    noc1_flit  = '0;
    noc0_valid = 1'b0;
    noc1_valid = 1'b0;

    // ch, type, id, last, addr, words
    pkt_tab[0] = {1'b0, dma_pkg::PKT_R2L_RESP, 2'd0, 1'b1, 32'h0000_0000, 8'd4};
    pkt_tab[1] = {1'b1, dma_pkg::PKT_L2R_RESP, 2'd1, 1'b0, 32'h0000_0000, 8'd0};
    pkt_tab[2] = {1'b0, dma_pkg::PKT_R2L_RESP, 2'd2, 1'b0, 32'h0000_0040, 8'd3};  // No flag
    pkt_tab[3] = {1'b1, dma_pkg::PKT_R2L_RESP, 2'd3, 1'b1, 32'h0000_0080, 8'd6};
    pkt_tab[4] = {1'b0, dma_pkg::PKT_R2L_RESP, 2'd1, 1'b1, 32'h0000_0100, 8'd24}; // Fills FIFO
    pkt_tab[5] = {1'b1, 2'd3,                  2'd2, 1'b1, 32'h0000_03c0, 8'd2};  // Unknown
    pkt_tab[6] = {1'b1, dma_pkg::PKT_R2L_RESP, 2'd0, 1'b1, 32'h0000_0200, 8'd20};
    pkt_tab[7] = {1'b0, dma_pkg::PKT_L2R_RESP, 2'd3, 1'b0, 32'h0000_0000, 8'd0};
    pkt_tab[8] = {1'b1, 2'd0,                  2'd1, 1'b1, 32'h0000_03e0, 8'd1};  // Unknown
    pkt_tab[9] = {1'b1, dma_pkg::PKT_R2L_RESP, 2'd2, 1'b1, 32'h0000_0300, 8'd5};
    for (int p = 0; p < NUM_PKTS; p++) begin
      build_packet(p);
    end
    timeout_limit = 40 * total_words + 200;

    repeat (2) @(posedge clk);
    rst <= 1'b0;

    fork
      begin
        for (int k = 0; k < stream_len[0]; k++) begin
          noc0_flit  <= stream[0][k];
          noc0_valid <= 1'b1;
          @(posedge clk);
          while (!noc0_ready) @(posedge clk);   // Held until accepted
        end
        noc0_valid <= 1'b0;
      end
      begin
        for (int k = 0; k < stream_len[1]; k++) begin
          noc1_flit  <= stream[1][k];
          noc1_valid <= 1'b1;
          @(posedge clk);
          while (!noc1_ready) @(posedge clk);
        end
        noc1_valid <= 1'b0;
      end
    join

    while (writes_seen != total_words || exp_done0.size() != 0 || exp_done1.size() != 0) begin
      @(posedge clk);
    end
    repeat (20) @(posedge clk);             // Window for stray writes or done pulses

    for (int p = 0; p < NUM_PKTS; p++) begin
      if (pkt_tab[p].ptype == dma_pkg::PKT_R2L_RESP) begin
        first = int'(pkt_tab[p].addr >> 2);
        for (int w = 0; w < pkt_tab[p].words; w++) begin
          idx = first + w;
          if (mem_hits[idx] == 0) begin
            abort_run($sformatf("Word %0d of packet %0d was never written", w, p));
          end
          if (mem_burst[idx] != mem_burst[first]) begin
            abort_run($sformatf("Packet %0d was split over more than one burst", p));
          end
          pos = mem_pos[first] + w;           // Beats of one burst sit back to back
          if (pos >= log_adr.size()) begin
            abort_run($sformatf("Packet %0d ended before all its beats were on the bus", p));
          end
          check_word(pkt_tab[p].addr + 32'(w * dma_pkg::WORD_BYTES), log_adr[pos],
                     data_tab[p][w], log_dat[pos]);
          check_cti(log_adr[pos],
                    (w == pkt_tab[p].words - 1) ? dma_pkg::CTI_END : dma_pkg::CTI_INCR,
                    log_cti[pos]);
        end
      end
    end

    if (i_dut.i_asserts.fail_count == 0) begin
      $display("Test completed successfully");
      $finish;
    end else begin
      abort_run("A Wishbone protocol assertion fired");
    end
  end

endmodule

`default_nettype wire

// ==== compile.f ====
logic/dma_pkg.sv
logic/dma_flit_fifo.sv
logic/dma_resp_writer.sv
logic/dma_wb_arbiter.sv
logic/dma_resp_top.sv
verification/dma_resp_asserts.sv
verification/dma_resp_tb.sv

// ==== Bender.yml ====
package:
  name: dma_resp

sources:
  - logic/dma_pkg.sv
  - logic/dma_flit_fifo.sv
  - logic/dma_resp_writer.sv
  - logic/dma_wb_arbiter.sv
  - logic/dma_resp_top.sv
  - target: test
    files:
      - verification/dma_resp_asserts.sv
      - verification/dma_resp_tb.sv
